//--- tlbEntryPkg.sv
`default_nettype none

package tlbEntryPkg;

  localparam int numEntries = 16;
  localparam int indexWidth = 4;
  localparam int vpn2Width = 19;
  localparam int pfnWidth = 24;
  localparam int asidWidth = 8;
  localparam int cacheWidth = 3;

  // MIPS cache attribute for uncached accesses
  localparam logic [cacheWidth-1:0] cacheUncached = 3'd2;

  // One entry maps an even/odd pair of 4 KiB pages
  typedef struct packed {
    logic [cacheWidth-1:0] c0;
    logic [cacheWidth-1:0] c1;
    logic [asidWidth-1:0]  asid;
    logic                  g;     // Global pages ignore the ASID
    logic [vpn2Width-1:0]  vpn2;
    logic [pfnWidth-1:0]   pfn1;
    logic                  d1;
    logic                  v1;
    logic [pfnWidth-1:0]   pfn0;
    logic                  d0;
    logic                  v0;
  } tlbEntry;

  typedef tlbEntry [numEntries-1:0] tlbEntryArr;

endpackage

`default_nettype wire

//--- tlbCmdPkg.sv
`default_nettype none

package tlbCmdPkg;

  typedef enum logic {
    cmdWrite = 1'b0,
    cmdProbe = 1'b1
  } tlbCmdOp;

  // Indexed write, the entry sits above the target slot
  typedef struct packed {
    tlbEntryPkg::tlbEntry                entry;
    logic [tlbEntryPkg::indexWidth-1:0]  index;
  } tlbWriteView;

  // Probe only looks at the VPN2 field, bits 74 to 56 of the word
  typedef struct packed {
    logic [14:0]                        unusedHi;
    logic [tlbEntryPkg::vpn2Width-1:0]  vpn2;
    logic [55:0]                        unusedLo;
  } tlbProbeView;

  typedef union packed {
    tlbWriteView writeView;
    tlbProbeView probeView;
  } tlbCmdWord;

  localparam int probeMissBit = 31;  // Index sits in the low bits

endpackage

`default_nettype wire

//--- tlbLookupIf.sv
`timescale 1ns/100ps
`default_nettype none

interface tlbLookupIf;
  import tlbEntryPkg::*;

  logic [31:0]           vaddr;
  logic [asidWidth-1:0]  asid;
  logic [31:0]           paddr;
  logic                  miss;
  logic                  valid;
  logic                  dirty;
  logic                  uncached;
  logic [indexWidth-1:0] hitIndex;  // Lowest matching slot

  modport requester (
    output vaddr, asid,
    input  paddr, miss, valid, dirty, uncached, hitIndex
  );

  modport matcher (
    input  vaddr, asid,
    output paddr, miss, valid, dirty, uncached, hitIndex
  );

endinterface

`default_nettype wire

//--- tlbEntryArray.sv
`timescale 1ns/100ps
`default_nettype none

module tlbEntryArray (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire                                 wrEn,
  input  wire [tlbEntryPkg::indexWidth-1:0]   wrIndex,
  input  var  tlbEntryPkg::tlbEntry           wrEntry,
  output tlbEntryPkg::tlbEntryArr             entries
);

  // The whole store is visible at once so every matcher can compare in parallel
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      entries <= '0;  // Zeroed slots still match VPN2 0 but read as invalid
    end else if (wrEn) begin
      entries[wrIndex] <= wrEntry;
    end
  end

endmodule

`default_nettype wire

//--- tlbMatcher.sv
`timescale 1ns/100ps
`default_nettype none

module tlbMatcher (
  input var tlbEntryPkg::tlbEntryArr entries,
  tlbLookupIf.matcher                lookup
);
  import tlbEntryPkg::*;

  logic [numEntries-1:0] matchVec;
  logic                  hit;
  logic [indexWidth-1:0] hitIdx;
  tlbEntry               hitEntry;
  logic                  oddPage;
  logic [pfnWidth-1:0]   pagePfn;
  logic [cacheWidth-1:0] pageAttr;
  logic                  pageValid;
  logic                  pageDirty;

  always_comb begin
    for (int i = 0; i < numEntries; i++) begin
      matchVec[i] = (entries[i].vpn2 == lookup.vaddr[31:13]) &&
                    (entries[i].g || (entries[i].asid == lookup.asid));
    end
  end

  // Scanning downwards leaves the lowest matching slot in hitIdx
  always_comb begin
    hitIdx = '0;
    for (int i = numEntries - 1; i >= 0; i--) begin
      if (matchVec[i]) begin
        hitIdx = indexWidth'(i);
      end
    end
  end

  assign hit = |matchVec;
  assign hitEntry = entries[hitIdx];
  assign oddPage = lookup.vaddr[12];

  always_comb begin
    if (oddPage) begin
      pagePfn   = hitEntry.pfn1;
      pageAttr  = hitEntry.c1;
      pageValid = hitEntry.v1;
      pageDirty = hitEntry.d1;
    end else begin
      pagePfn   = hitEntry.pfn0;
      pageAttr  = hitEntry.c0;
      pageValid = hitEntry.v0;
      pageDirty = hitEntry.d0;
    end
  end

  // Only 20 PFN bits reach a 32-bit physical address
  assign lookup.paddr    = hit ? {pagePfn[19:0], lookup.vaddr[11:0]} : '0;
  assign lookup.miss     = !hit;
  assign lookup.valid    = hit && pageValid;
  assign lookup.dirty    = hit && pageDirty;
  assign lookup.uncached = hit && (pageAttr == cacheUncached);
  assign lookup.hitIndex = hitIdx;  // Already zero when nothing matches

endmodule

`default_nettype wire

//--- tlbCmdPort.sv
`timescale 1ns/100ps
`default_nettype none

module tlbCmdPort (
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire                                 cmdReq,
  output logic                                cmdAck,
  input  var  tlbCmdPkg::tlbCmdOp             cmdOp,
  input  var  tlbCmdPkg::tlbCmdWord           cmdWord,
  input  wire [tlbEntryPkg::asidWidth-1:0]    asid,
  output logic                                wrEn,
  output logic [tlbEntryPkg::indexWidth-1:0]  wrIndex,
  output tlbEntryPkg::tlbEntry                wrEntry,
  tlbLookupIf.requester                       probe,
  output logic [31:0]                         probeResult
);
  import tlbEntryPkg::*;
  import tlbCmdPkg::*;

  typedef enum logic [1:0] {stIdle, stExec, stAck, stRelease} cmdState;

  cmdState     state;
  tlbCmdOp     curOp;
  tlbCmdWord   curWord;
  logic        start;
  logic [31:0] probeWord;

  assign start = (state == stIdle) && cmdReq && !cmdAck;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= stIdle;
      cmdAck <= 1'b0;
      curOp  <= cmdWrite;
    end else begin
      case (state)
        stIdle: begin
          cmdAck <= 1'b0;  // Falls one edge after req was seen low
          if (start) begin
            curOp <= cmdOp;
            state <= stExec;
          end
        end
        stExec: state <= stAck;  // Write lands or probe result is taken here
        stAck: begin
          cmdAck <= 1'b1;
          state  <= stRelease;
        end
        stRelease: begin
          if (!cmdReq) begin
            state <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      curWord <= cmdWord;
    end
  end

  assign wrEn    = (state == stExec) && (curOp == cmdWrite);
  assign wrIndex = curWord.writeView.index;
  assign wrEntry = curWord.writeView.entry;

  // Probe searches with the page-pair base address
  assign probe.vaddr = {curWord.probeView.vpn2, 13'b0};
  assign probe.asid  = asid;

  always_comb begin
    probeWord = '0;
    probeWord[probeMissBit] = probe.miss;
    probeWord[indexWidth-1:0] = probe.hitIndex;
  end

  // Held until the next probe so it stays valid across the ack phase
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      probeResult <= '0;
    end else if ((state == stExec) && (curOp == cmdProbe)) begin
      probeResult <= probeWord;
    end
  end

endmodule

`default_nettype wire

//--- tlbTop.sv
`timescale 1ns/100ps
`default_nettype none

module tlbTop (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                cmdReq,
  output logic                               cmdAck,
  input  var  tlbCmdPkg::tlbCmdOp            cmdOp,
  input  var  tlbCmdPkg::tlbCmdWord          cmdWord,
  input  wire [tlbEntryPkg::asidWidth-1:0]   asid,
  output logic [31:0]                        probeResult,
  input  wire [31:0]                         insVaddr,
  output logic [31:0]                        insPaddr,
  output logic                               insMiss,
  output logic                               insValid,
  output logic                               insDirty,
  output logic                               insUncached,
  input  wire [31:0]                         dataVaddr,
  output logic [31:0]                        dataPaddr,
  output logic                               dataMiss,
  output logic                               dataValid,
  output logic                               dataDirty,
  output logic                               dataUncached
);
  import tlbEntryPkg::*;

  logic                  wrEn;
  logic [indexWidth-1:0] wrIndex;
  tlbEntry               wrEntry;
  tlbEntryArr            entries;

  tlbLookupIf insLookup ();
  tlbLookupIf dataLookup ();
  tlbLookupIf probeLookup ();

  tlbCmdPort i_cmdPort (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmdReq      (cmdReq),
    .cmdAck      (cmdAck),
    .cmdOp       (cmdOp),
    .cmdWord     (cmdWord),
    .asid        (asid),
    .wrEn        (wrEn),
    .wrIndex     (wrIndex),
    .wrEntry     (wrEntry),
    .probe       (probeLookup.requester),
    .probeResult (probeResult)
  );

  tlbEntryArray i_entryArray (
    .clk     (clk),
    .rst_n   (rst_n),
    .wrEn    (wrEn),
    .wrIndex (wrIndex),
    .wrEntry (wrEntry),
    .entries (entries)
  );

  tlbMatcher insMatcher (.entries(entries), .lookup(insLookup.matcher));
  tlbMatcher dataMatcher (.entries(entries), .lookup(dataLookup.matcher));
  tlbMatcher probeMatcher (.entries(entries), .lookup(probeLookup.matcher));

  // Both translation ports search under the current ASID
  assign insLookup.vaddr  = insVaddr;
  assign insLookup.asid   = asid;
  assign dataLookup.vaddr = dataVaddr;
  assign dataLookup.asid  = asid;

  assign insPaddr    = insLookup.paddr;
  assign insMiss     = insLookup.miss;
  assign insValid    = insLookup.valid;
  assign insDirty    = insLookup.dirty;
  assign insUncached = insLookup.uncached;

  assign dataPaddr    = dataLookup.paddr;
  assign dataMiss     = dataLookup.miss;
  assign dataValid    = dataLookup.valid;
  assign dataDirty    = dataLookup.dirty;
  assign dataUncached = dataLookup.uncached;

endmodule

`default_nettype wire

//--- tbTlbTop.sv
`timescale 1ns/100ps
`default_nettype none

module tbTlbTop;
  import tlbEntryPkg::*;
  import tlbCmdPkg::*;

  typedef struct packed {
    logic                  miss;
    logic                  valid;
    logic                  dirty;
    logic                  uncached;
    logic [indexWidth-1:0] idx;
    logic [31:0]           paddr;
  } lookupResult;

  logic clk;
  logic rst_n;
  logic cmdReq;
  logic cmdAck;
  tlbCmdOp cmdOp;
  tlbCmdWord cmdWord;
  logic [asidWidth-1:0] asid;
  logic [31:0] probeResult;
  logic [31:0] insVaddr, insPaddr, dataVaddr, dataPaddr;
  logic insMiss, insValid, insDirty, insUncached;
  logic dataMiss, dataValid, dataDirty, dataUncached;

  tlbEntry model [numEntries];  // Scoreboard copy of the entry store
  logic [31:0] lfsrState;
  int ackFallWait;  // Negedges from dropping req until ack was seen low

  tlbTop i_dut (
    .clk(clk), .rst_n(rst_n), .cmdReq(cmdReq), .cmdAck(cmdAck), .cmdOp(cmdOp),
    .cmdWord(cmdWord), .asid(asid), .probeResult(probeResult),
    .insVaddr(insVaddr), .insPaddr(insPaddr), .insMiss(insMiss), .insValid(insValid),
    .insDirty(insDirty), .insUncached(insUncached),
    .dataVaddr(dataVaddr), .dataPaddr(dataPaddr), .dataMiss(dataMiss),
    .dataValid(dataValid), .dataDirty(dataDirty), .dataUncached(dataUncached)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Taps for x^32 + x^22 + x^2 + x + 1 with one step per drawn bit
  function automatic logic [31:0] drawBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
    if (actual !== expected) begin
      failRun($sformatf("CHECK FAILED at %0t: %s (got %h, expected %h)",
                        $time, msg, actual, expected));
    end
  endtask

  // First matching slot wins and vaddr bit 12 selects its page
  function automatic lookupResult modelLookup(input logic [31:0] va,
                                              input logic [asidWidth-1:0] a);
    lookupResult r;
    tlbEntry e;
    logic found;
    r = '0;
    found = 1'b0;
    for (int i = 0; i < numEntries; i++) begin
      e = model[i];
      if (!found && e.vpn2 == va[31:13] && (e.g || e.asid == a)) begin
        found = 1'b1;
        r.idx = i[indexWidth-1:0];
        r.paddr = {(va[12] ? e.pfn1[19:0] : e.pfn0[19:0]), va[11:0]};
        r.valid = va[12] ? e.v1 : e.v0;
        r.dirty = va[12] ? e.d1 : e.d0;
        r.uncached = (va[12] ? e.c1 : e.c0) == 3'd2;
      end
    end
    r.miss = !found;
    return r;
  endfunction

  function automatic tlbEntry makeEntry(input logic [vpn2Width-1:0] vpn2,
      input logic [asidWidth-1:0] a, input logic g, input logic [pfnWidth-1:0] pfn0,
      input logic [pfnWidth-1:0] pfn1, input logic [3:0] dv, input logic [5:0] attrs);
    tlbEntry e;
    e = '0;
    e.vpn2 = vpn2;
    e.asid = a;
    e.g = g;
    e.pfn0 = pfn0;
    e.pfn1 = pfn1;
    {e.d1, e.v1, e.d0, e.v0} = dv;
    {e.c1, e.c0} = attrs;
    return e;
  endfunction

  task automatic doCommand(input tlbCmdOp op, input tlbCmdWord word);
    int waited;
    @(negedge clk);
    cmdOp = op;
    cmdWord = word;
    cmdReq = 1'b1;
    waited = 0;
    while (!cmdAck) begin
      @(negedge clk);
      waited++;
      if (waited > 20) failRun("handshake timed out waiting for cmdAck to rise");
    end
    cmdReq = 1'b0;
    waited = 0;
    while (cmdAck) begin
      @(negedge clk);
      waited++;
      if (waited > 20) failRun("handshake timed out waiting for cmdAck to fall");
    end
    ackFallWait = waited;
  endtask

  task automatic writeEntry(input int idx, input tlbEntry e);
    tlbCmdWord w;
    w = '0;
    w.writeView.entry = e;
    w.writeView.index = idx[indexWidth-1:0];
    doCommand(cmdWrite, w);
    model[idx] = e;
  endtask

  task automatic probeVpn(input logic [vpn2Width-1:0] vpn2, input logic [asidWidth-1:0] a);
    tlbCmdWord w;
    lookupResult r;
    w = '0;
    w.probeView.vpn2 = vpn2;
    @(negedge clk);
    asid = a;
    doCommand(cmdProbe, w);
    r = modelLookup({vpn2, 13'b0}, a);
    checkEq(probeResult, r.miss ? 32'h8000_0000 : {28'b0, r.idx}, "probe result");
  endtask

  task automatic lookupBoth(input logic [31:0] insVa, input logic [31:0] dataVa,
                            input logic [asidWidth-1:0] a);
    lookupResult ri, rd;
    @(negedge clk);
    insVaddr = insVa;
    dataVaddr = dataVa;
    asid = a;
    @(posedge clk);  // Store is idle so the combinational outputs have settled
    ri = modelLookup(insVa, a);
    rd = modelLookup(dataVa, a);
    checkEq(insMiss, ri.miss, "ins miss");
    checkEq(insPaddr, ri.paddr, "ins paddr");
    checkEq(insValid, ri.valid, "ins valid");
    checkEq(insDirty, ri.dirty, "ins dirty");
    checkEq(insUncached, ri.uncached, "ins uncached");
    checkEq(dataMiss, rd.miss, "data miss");
    checkEq(dataPaddr, rd.paddr, "data paddr");
    checkEq(dataValid, rd.valid, "data valid");
    checkEq(dataDirty, rd.dirty, "data dirty");
    checkEq(dataUncached, rd.uncached, "data uncached");
  endtask

  task automatic testReset();
    checkEq(cmdAck, 1'b0, "ack low after reset");
    checkEq(probeResult, 32'h0, "probe result clear after reset");
    lookupBoth(32'h1234_5678, 32'h0000_0000, 8'h00);
    checkEq(insMiss, 1'b1, "nonzero VPN2 misses after reset");
    checkEq(dataMiss, 1'b0, "zeroed slot matches address 0");
    checkEq(dataValid, 1'b0, "zeroed slot is invalid");
    probeVpn(19'h0, 8'h00);
    checkEq(probeResult, 32'h0, "address 0 hits index 0");
  endtask

  task automatic testWriteTranslate();
    for (int i = 0; i < 4; i++) begin
      writeEntry(i, makeEntry(19'(19'h1_0000 + i), 8'h05, 1'b0, 24'(24'h00_0100 + i),
                              24'(24'hab_0200 + i), i[3:0] ^ 4'b0101, 6'o33));
    end
    for (int i = 0; i < 4; i++) begin
      lookupBoth({19'(19'h1_0000 + i), 1'b0, 12'h3a4}, {19'(19'h1_0000 + i), 1'b1, 12'hffc},
                 8'h05);
    end
    checkEq(dataPaddr, 32'hb0_203ffc, "odd page uses the low 20 PFN bits");
  endtask

  task automatic testAsid();
    writeEntry(5, makeEntry(19'h2_2222, 8'h11, 1'b0, 24'h5, 24'h6, 4'b1111, 6'o00));
    writeEntry(6, makeEntry(19'h3_3333, 8'h44, 1'b1, 24'h7, 24'h8, 4'b0011, 6'o00));
    lookupBoth(32'h4444_4000, 32'h6666_6000, 8'h11);
    checkEq(insMiss, 1'b0, "own ASID hits");
    lookupBoth(32'h4444_4000, 32'h6666_7000, 8'h12);
    checkEq(insMiss, 1'b1, "foreign ASID misses");
    checkEq(dataMiss, 1'b0, "global entry hits any ASID");
    lookupBoth(32'h4444_5000, 32'h6666_6abc, 8'h00);
  endtask

  task automatic testProbe();
    probeVpn(19'h1_0001, 8'h05);
    checkEq(probeResult, 32'h1, "probe finds index 1");
    probeVpn(19'h7_1234, 8'h05);
    checkEq(probeResult, 32'h8000_0000, "absent VPN2 sets the miss bit");
    writeEntry(12, makeEntry(19'h4_4444, 8'h00, 1'b1, 24'hc, 24'hd, 4'b0101, 6'o22));
    writeEntry(9, makeEntry(19'h4_4444, 8'h00, 1'b1, 24'h9, 24'ha, 4'b1010, 6'o00));
    probeVpn(19'h4_4444, 8'h33);
    checkEq(probeResult, 32'h9, "lower index wins on a double match");
    checkEq(ackFallWait, 32'd2, "ack falls one edge after req is sampled low");
    lookupBoth(32'h8888_8000, 32'h8888_9000, 8'h33);
  endtask

  task automatic testUncachedRandom();
    int slot;
    logic [31:0] va;
    for (int i = 0; i < numEntries; i++) begin
      // Low VPN2 bits carry the slot so no two entries collide
      writeEntry(i, makeEntry({15'(drawBits(15)), i[3:0]}, 8'(drawBits(8)), 1'(drawBits(1)),
                              24'(drawBits(24)), 24'(drawBits(24)), 4'(drawBits(4)),
                              {3'(drawBits(3)), 1'b0, 2'(drawBits(2))}));
    end
    for (int n = 0; n < 40; n++) begin
      slot = drawBits(4);
      va = {model[slot].vpn2, 13'(drawBits(13))};
      lookupBoth(va, drawBits(32), drawBits(1) ? model[slot].asid : 8'(drawBits(8)));
    end
  endtask

  initial begin
    lfsrState = 32'hf404dba8;
    ackFallWait = 0;
    rst_n = 1'b0;
    cmdReq = 1'b0;
    cmdOp = cmdWrite;
    cmdWord = '0;
    asid = '0;
    insVaddr = '0;
    dataVaddr = '0;
    for (int i = 0; i < numEntries; i++) model[i] = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    testReset();
    testWriteTranslate();
    testAsid();
    testProbe();
    testUncachedRandom();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
tlbEntryPkg.sv
tlbCmdPkg.sv
tlbLookupIf.sv
tlbEntryArray.sv
tlbMatcher.sv
tlbCmdPort.sv
tlbTop.sv
tbTlbTop.sv

//--- Bender.yml
package:
  name: tlb

sources:
  - tlbEntryPkg.sv
  - tlbCmdPkg.sv
  - tlbLookupIf.sv
  - tlbEntryArray.sv
  - tlbMatcher.sv
  - tlbCmdPort.sv
  - tlbTop.sv
  - target: test
    files:
      - tbTlbTop.sv
